/* hdl/sdr_defines.svh */
// sizes and counts for the north SDR row, included by every file that needs a width
`ifndef SDR_DEFINES_SVH
`define SDR_DEFINES_SVH

// row geometry
`define SDR_NUM_PODS_X 2
`define SDR_NUM_TILES_X 2
`define SDR_NUM_COLS (`SDR_NUM_PODS_X * `SDR_NUM_TILES_X)

// link buffering and credit return
`define SDR_LG_FIFO_DEPTH 2
`define SDR_LG_TOKEN_DECIMATION 1

// forward packet fields
`define SDR_ADDR_W 8
`define SDR_DATA_W 16
`define SDR_X_CORD_W 4
`define SDR_Y_CORD_W 3

`endif

/* hdl/sdr_pkg.sv */
// packet, link, coordinate and tag types shared by the SDR row RTL and its testbench
`default_nettype none

`include "sdr_defines.svh"

package sdr_pkg;

  // one forward network packet
  typedef struct packed {
    logic [`SDR_ADDR_W-1:0]   addr;
    logic [`SDR_DATA_W-1:0]   data;
    logic [`SDR_X_CORD_W-1:0] x_cord;
    logic [`SDR_Y_CORD_W-1:0] y_cord;
  } fwd_pkt_s;

  // io side beat, qualified by v only
  typedef struct packed {
    logic     v;
    fwd_pkt_s pkt;
  } fwd_link_s;

  typedef struct packed {
    logic [`SDR_X_CORD_W-1:0] x;
    logic [`SDR_Y_CORD_W-1:0] y;
  } cord_s;

  // data loads the pod reset bit when v is high
  typedef struct packed {
    logic v;
    logic data;
  } tag_s;

endpackage

`default_nettype wire

/* hdl/sdr_link_out.sv */
// outbound forward link: buffers core packets and sends them to the IO side on credit
`timescale 1ns/100ps
`default_nettype none

`include "sdr_defines.svh"

module sdr_link_out (
  input  logic               core_clk_i
  , input  logic             rst_n_i

  // core side, valid/ready
  , input  logic             core_fwd_v_i
  , input  sdr_pkg::fwd_pkt_s core_fwd_pkt_i
  , output logic             core_fwd_ready_o

  // io side, valid plus returned tokens
  , output sdr_pkg::fwd_link_s io_fwd_o
  , input  logic             io_fwd_token_i
);

  localparam int unsigned depth_lp = 1 << `SDR_LG_FIFO_DEPTH;
  localparam int unsigned cnt_w_lp = `SDR_LG_FIFO_DEPTH + 1;
  localparam logic [cnt_w_lp-1:0] token_credits_lp = cnt_w_lp'(1 << `SDR_LG_TOKEN_DECIMATION);

  sdr_pkg::fwd_pkt_s mem [depth_lp];

  logic [`SDR_LG_FIFO_DEPTH-1:0] wr_ptr_r;
  logic [`SDR_LG_FIFO_DEPTH-1:0] rd_ptr_r;
  logic [cnt_w_lp-1:0]           count_r;
  logic [cnt_w_lp-1:0]           credit_r;
  logic                          enq;
  logic                          send;

  assign core_fwd_ready_o = (count_r != cnt_w_lp'(depth_lp));
  assign enq = core_fwd_v_i & core_fwd_ready_o;

  // head goes out whenever the far end has room for it
  assign send = (count_r != '0) & (credit_r != '0);

  assign io_fwd_o = '{v: send, pkt: mem[rd_ptr_r]};

  always_ff @(posedge core_clk_i) begin
    if (enq) begin
      mem[wr_ptr_r] <= core_fwd_pkt_i;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      // far end buffer starts empty
      credit_r <= cnt_w_lp'(depth_lp);
    end else begin
      if (enq) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (send) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      count_r <= count_r + cnt_w_lp'(enq) - cnt_w_lp'(send);
      // one token returns a whole decimation group of credits
      credit_r <= credit_r - cnt_w_lp'(send)
                  + (io_fwd_token_i ? token_credits_lp : '0);
    end
  end

endmodule

`default_nettype wire

/* hdl/sdr_link_in.sv */
// inbound forward link: buffers IO beats for the core and returns decimated tokens
`timescale 1ns/100ps
`default_nettype none

`include "sdr_defines.svh"

module sdr_link_in (
  input  logic               core_clk_i
  , input  logic             rst_n_i

  // io side
  , input  sdr_pkg::fwd_link_s io_fwd_i
  , output logic             io_fwd_token_o

  // core side, valid/ready
  , output logic             core_fwd_v_o
  , output sdr_pkg::fwd_pkt_s core_fwd_pkt_o
  , input  logic             core_fwd_ready_i
);

  localparam int unsigned depth_lp = 1 << `SDR_LG_FIFO_DEPTH;
  localparam int unsigned cnt_w_lp = `SDR_LG_FIFO_DEPTH + 1;

  sdr_pkg::fwd_pkt_s mem [depth_lp];

  logic [`SDR_LG_FIFO_DEPTH-1:0]       wr_ptr_r;
  logic [`SDR_LG_FIFO_DEPTH-1:0]       rd_ptr_r;
  logic [cnt_w_lp-1:0]                 count_r;
  logic [`SDR_LG_TOKEN_DECIMATION-1:0] dec_cnt_r;
  logic                                token_r;
  logic                                full;
  logic                                push;
  logic                                pop;

  assign full = (count_r == cnt_w_lp'(depth_lp));
  // sender is credit limited, so a full FIFO never sees a beat
  assign push = io_fwd_i.v & ~full;

  assign core_fwd_v_o   = (count_r != '0);
  assign core_fwd_pkt_o = mem[rd_ptr_r];
  assign pop = core_fwd_v_o & core_fwd_ready_i;

  assign io_fwd_token_o = token_r;

  always_ff @(posedge core_clk_i) begin
    if (push) begin
      mem[wr_ptr_r] <= io_fwd_i.pkt;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_r  <= '0;
      rd_ptr_r  <= '0;
      count_r   <= '0;
      dec_cnt_r <= '0;
      token_r   <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop) begin
        rd_ptr_r  <= rd_ptr_r + 1'b1;
        dec_cnt_r <= dec_cnt_r + 1'b1;
      end
      count_r <= count_r + cnt_w_lp'(push) - cnt_w_lp'(pop);
      // token on the last dequeue of each group
      token_r <= pop & (dec_cnt_r == '1);
    end
  end

endmodule

`default_nettype wire

/* hdl/sdr_north_tile.sv */
// one column of the north SDR row: retimes reset and coordinates, joins both forward links
`timescale 1ns/100ps
`default_nettype none

module sdr_north_tile (
  input  logic                 core_clk_i
  , input  logic               rst_n_i

  , input  logic               core_reset_i
  , output logic               core_reset_o

  , input  sdr_pkg::cord_s     global_cord_i
  , output sdr_pkg::cord_s     core_cord_o

  // outbound link
  , input  logic               core_fwd_v_i
  , input  sdr_pkg::fwd_pkt_s  core_fwd_pkt_i
  , output logic               core_fwd_ready_o
  , output sdr_pkg::fwd_link_s io_fwd_o
  , input  logic               io_fwd_token_i

  // inbound link
  , input  sdr_pkg::fwd_link_s io_fwd_i
  , output logic               io_fwd_token_o
  , output logic               core_fwd_v_o
  , output sdr_pkg::fwd_pkt_s  core_fwd_pkt_o
  , input  logic               core_fwd_ready_i
);

  logic           core_reset_r;
  sdr_pkg::cord_s core_cord_r;

  // pods stay held until a tag releases them
  always_ff @(posedge core_clk_i) begin
    if (!rst_n_i) begin
      core_reset_r <= 1'b1;
    end else begin
      core_reset_r <= core_reset_i;
    end
  end

  always_ff @(posedge core_clk_i) begin
    core_cord_r <= global_cord_i;
  end

  assign core_reset_o = core_reset_r;
  assign core_cord_o  = core_cord_r;

  sdr_link_out link_out (
    .core_clk_i        (core_clk_i)
    ,.rst_n_i          (rst_n_i)
    ,.core_fwd_v_i     (core_fwd_v_i)
    ,.core_fwd_pkt_i   (core_fwd_pkt_i)
    ,.core_fwd_ready_o (core_fwd_ready_o)
    ,.io_fwd_o         (io_fwd_o)
    ,.io_fwd_token_i   (io_fwd_token_i)
  );

  sdr_link_in link_in (
    .core_clk_i        (core_clk_i)
    ,.rst_n_i          (rst_n_i)
    ,.io_fwd_i         (io_fwd_i)
    ,.io_fwd_token_o   (io_fwd_token_o)
    ,.core_fwd_v_o     (core_fwd_v_o)
    ,.core_fwd_pkt_o   (core_fwd_pkt_o)
    ,.core_fwd_ready_i (core_fwd_ready_i)
  );

endmodule

`default_nettype wire

/* hdl/pod_row_sdr_north.sv */
// top of the north SDR row: tag driven pod resets, retiming and one SDR tile per column
`timescale 1ns/100ps
`default_nettype none

`include "sdr_defines.svh"

module pod_row_sdr_north (
  input  logic ext_clk_i
  , input  logic rst_n_i

  , input  sdr_pkg::tag_s  [`SDR_NUM_PODS_X-1:0] pod_tags_i
  , input  sdr_pkg::cord_s [`SDR_NUM_COLS-1:0]   global_cord_i
  , output logic           [`SDR_NUM_COLS-1:0]   core_reset_o
  , output sdr_pkg::cord_s [`SDR_NUM_COLS-1:0]   core_cord_o

  // core side links
  , input  logic              [`SDR_NUM_COLS-1:0] core_fwd_v_i
  , input  sdr_pkg::fwd_pkt_s [`SDR_NUM_COLS-1:0] core_fwd_pkt_i
  , output logic              [`SDR_NUM_COLS-1:0] core_fwd_ready_o
  , output logic              [`SDR_NUM_COLS-1:0] core_fwd_v_o
  , output sdr_pkg::fwd_pkt_s [`SDR_NUM_COLS-1:0] core_fwd_pkt_o
  , input  logic              [`SDR_NUM_COLS-1:0] core_fwd_ready_i

  // io side links
  , output sdr_pkg::fwd_link_s [`SDR_NUM_COLS-1:0] io_fwd_o
  , input  logic               [`SDR_NUM_COLS-1:0] io_fwd_token_i
  , input  sdr_pkg::fwd_link_s [`SDR_NUM_COLS-1:0] io_fwd_i
  , output logic               [`SDR_NUM_COLS-1:0] io_fwd_token_o
);

  // no clock generator, the external clock runs the core
  logic core_clk;
  assign core_clk = ext_clk_i;

  logic [`SDR_NUM_PODS_X-1:0][`SDR_NUM_TILES_X-1:0] pod_reset;

  for (genvar p = 0; p < `SDR_NUM_PODS_X; p++) begin : pod
    logic       tag_reset_r;
    logic [1:0] reset_chain_r;

    always_ff @(posedge core_clk) begin
      if (!rst_n_i) begin
        tag_reset_r   <= 1'b1;
        reset_chain_r <= '1;
      end else begin
        if (pod_tags_i[p].v) begin
          tag_reset_r <= pod_tags_i[p].data;
        end
        reset_chain_r <= {reset_chain_r[0], tag_reset_r};
      end
    end

    // same reset for every column of the pod
    assign pod_reset[p] = {`SDR_NUM_TILES_X{reset_chain_r[1]}};
  end

  for (genvar c = 0; c < `SDR_NUM_COLS; c++) begin : col
    sdr_north_tile tile (
      .core_clk_i        (core_clk)
      ,.rst_n_i          (rst_n_i)
      ,.core_reset_i     (pod_reset[c / `SDR_NUM_TILES_X][c % `SDR_NUM_TILES_X])
      ,.core_reset_o     (core_reset_o[c])
      ,.global_cord_i    (global_cord_i[c])
      ,.core_cord_o      (core_cord_o[c])
      ,.core_fwd_v_i     (core_fwd_v_i[c])
      ,.core_fwd_pkt_i   (core_fwd_pkt_i[c])
      ,.core_fwd_ready_o (core_fwd_ready_o[c])
      ,.io_fwd_o         (io_fwd_o[c])
      ,.io_fwd_token_i   (io_fwd_token_i[c])
      ,.io_fwd_i         (io_fwd_i[c])
      ,.io_fwd_token_o   (io_fwd_token_o[c])
      ,.core_fwd_v_o     (core_fwd_v_o[c])
      ,.core_fwd_pkt_o   (core_fwd_pkt_o[c])
      ,.core_fwd_ready_i (core_fwd_ready_i[c])
    );
  end

endmodule

`default_nettype wire

/* tb/pod_row_sdr_chk.sv */
// protocol assertions for the forward links, bound into every outbound and inbound link
`timescale 1ns/100ps
`default_nettype none

`include "sdr_defines.svh"

module pod_row_sdr_chk (
  input  logic                clk_i
  , input  logic              rst_n_i

  // outbound send side and returned tokens
  , input  logic              beat_v_i
  , input  logic              token_i

  // inbound arrival and core delivery
  , input  logic              arrive_i
  , input  logic              full_i
  , input  logic              v_i
  , input  logic              ready_i
  , input  sdr_pkg::fwd_pkt_s pkt_i
);

  // free entries in the far end buffer, as the far end counts them
  int far_room_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      far_room_r <= 1 << `SDR_LG_FIFO_DEPTH;
    end else begin
      far_room_r <= far_room_r - int'(beat_v_i)
                    + (token_i ? (1 << `SDR_LG_TOKEN_DECIMATION) : 0);
    end
  end

  credit_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    beat_v_i |-> (far_room_r > 0))
    else $error("outbound beat sent with zero credits");

  no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    arrive_i |-> !full_i)
    else $error("inbound beat arrived while the FIFO was full");

  // delivery holds until the consumer takes it
  stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (v_i && !ready_i) |=> (v_i && $stable(pkt_i)))
    else $error("core_fwd_v_o or its packet changed while stalled");

endmodule

bind sdr_link_out pod_row_sdr_chk out_chk (
  .clk_i(core_clk_i), .rst_n_i(rst_n_i), .beat_v_i(io_fwd_o.v), .token_i(io_fwd_token_i),
  .arrive_i(1'b0), .full_i(1'b0), .v_i(1'b0), .ready_i(1'b0), .pkt_i('0)
);

bind sdr_link_in pod_row_sdr_chk in_chk (
  .clk_i(core_clk_i), .rst_n_i(rst_n_i), .beat_v_i(1'b0), .token_i(1'b0),
  .arrive_i(io_fwd_i.v), .full_i(full), .v_i(core_fwd_v_o), .ready_i(core_fwd_ready_i),
  .pkt_i(core_fwd_pkt_o)
);

`default_nettype wire

/* tb/tb_pod_row_sdr.sv */
// testbench for the north SDR row, drives tags, coordinates and both forward links per column
`timescale 1ns/100ps
`default_nettype none

`include "sdr_defines.svh"

module tb_pod_row_sdr;

  localparam int num_cols_lp = `SDR_NUM_COLS;
  localparam int num_pkts_lp = 12;
  localparam int fifo_cred_lp = 1 << `SDR_LG_FIFO_DEPTH;
  localparam int tok_cred_lp = 1 << `SDR_LG_TOKEN_DECIMATION;
  // reset and tag phases, then a slow random pace per packet
  localparam int max_cycles_lp = 40 + 40 * num_pkts_lp;

  logic clk;
  logic rst_n;
  sdr_pkg::tag_s      [`SDR_NUM_PODS_X-1:0] pod_tags;
  sdr_pkg::cord_s     [num_cols_lp-1:0] global_cord;
  sdr_pkg::cord_s     [num_cols_lp-1:0] core_cord;
  logic               [num_cols_lp-1:0] core_reset;
  logic               [num_cols_lp-1:0] out_v;
  sdr_pkg::fwd_pkt_s  [num_cols_lp-1:0] out_pkt;
  logic               [num_cols_lp-1:0] out_ready;
  logic               [num_cols_lp-1:0] in_v;
  sdr_pkg::fwd_pkt_s  [num_cols_lp-1:0] in_pkt;
  logic               [num_cols_lp-1:0] in_ready;
  sdr_pkg::fwd_link_s [num_cols_lp-1:0] io_out;
  logic               [num_cols_lp-1:0] io_tok_in;
  sdr_pkg::fwd_link_s [num_cols_lp-1:0] io_in;
  logic               [num_cols_lp-1:0] io_tok_out;

  logic [31:0] rng = 32'd4;
  int cycles, val_errs, proto_errs;
  bit run_links, tok_en, cord_ok;
  // per column producer, far end and consumer state
  int sent [num_cols_lp], out_rcvd [num_cols_lp], far_cred [num_cols_lp];
  int tok_owed [num_cols_lp], tok_wait [num_cols_lp], in_sent [num_cols_lp];
  int in_cred [num_cols_lp], deq [num_cols_lp], in_toks [num_cols_lp];
  bit enq_fire [num_cols_lp], stall_prev [num_cols_lp];
  sdr_pkg::fwd_pkt_s stall_pkt [num_cols_lp];
  sdr_pkg::cord_s cord_prev [num_cols_lp];

  pod_row_sdr_north dut0 (
    .ext_clk_i         (clk)
    ,.rst_n_i          (rst_n)
    ,.pod_tags_i       (pod_tags)
    ,.global_cord_i    (global_cord)
    ,.core_reset_o     (core_reset)
    ,.core_cord_o      (core_cord)
    ,.core_fwd_v_i     (out_v)
    ,.core_fwd_pkt_i   (out_pkt)
    ,.core_fwd_ready_o (out_ready)
    ,.core_fwd_v_o     (in_v)
    ,.core_fwd_pkt_o   (in_pkt)
    ,.core_fwd_ready_i (in_ready)
    ,.io_fwd_o         (io_out)
    ,.io_fwd_token_i   (io_tok_in)
    ,.io_fwd_i         (io_in)
    ,.io_fwd_token_o   (io_tok_out)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // n-th packet of a column, inbound packets use n from 64 up
  function automatic sdr_pkg::fwd_pkt_s ref_pkt(input int col, input int n);
    logic [31:0] s;
    s = xorshift(xorshift((32'(col) << 24) | (32'(n) << 8) | 32'd4));
    return sdr_pkg::fwd_pkt_s'(s[30:0]);
  endfunction

  function automatic int min_of(input int a [num_cols_lp]);
    int m;
    m = a[0];
    for (int c = 1; c < num_cols_lp; c++) begin
      if (a[c] < m) m = a[c];
    end
    return m;
  endfunction

  task automatic check(input string name, input int col, input logic [31:0] got_v,
                       input logic [31:0] exp_v);
    if (got_v !== exp_v) begin
      val_errs++;
      $display("error: %s[%0d] got %h expected %h", name, col, got_v, exp_v);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles_lp) begin
      $display("timeout, the links did not finish within %0d cycles", max_cycles_lp);
      $display("Simulation failed");
      $finish;
    end
  end

  always @(posedge clk) begin
    logic [31:0] r;
    for (int c = 0; c < num_cols_lp; c++) begin
      rng = xorshift(rng);
      r = rng;
      global_cord[c] <= sdr_pkg::cord_s'(r[6:0]);
      if (enq_fire[c]) sent[c] = sent[c] + 1;
      out_v[c]   <= run_links && (sent[c] < num_pkts_lp);
      out_pkt[c] <= ref_pkt(c, sent[c]);
      // outbound far end returns tokens after a short random wait
      io_tok_in[c] <= 1'b0;
      if (tok_wait[c] > 0) begin
        tok_wait[c] = tok_wait[c] - 1;
      end else if (tok_en && tok_owed[c] > 0) begin
        io_tok_in[c] <= 1'b1;
        tok_owed[c] = tok_owed[c] - 1;
        tok_wait[c] = int'(r[9:8]);
      end
      // inbound far end sends only on credit
      io_in[c] <= '0;
      if (run_links && in_cred[c] > 0 && in_sent[c] < num_pkts_lp && r[12]) begin
        io_in[c] <= '{v: 1'b1, pkt: ref_pkt(c, 64 + in_sent[c])};
        in_sent[c] = in_sent[c] + 1;
        in_cred[c] = in_cred[c] - 1;
      end
      in_ready[c] <= r[16] | r[17];
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      for (int c = 0; c < num_cols_lp; c++) begin
        enq_fire[c] = out_v[c] & out_ready[c];
        if (cord_ok) check("core_cord_o", c, 32'(core_cord[c]), 32'(cord_prev[c]));
        cord_prev[c] = global_cord[c];
        if (io_out[c].v) begin
          if (far_cred[c] == 0) begin
            proto_errs++;
            $display("column %0d sent an outbound beat with no far-end credit left", c);
          end
          check("io_fwd_o.pkt", c, 32'(io_out[c].pkt), 32'(ref_pkt(c, out_rcvd[c])));
          out_rcvd[c]++;
          far_cred[c]--;
          if (out_rcvd[c] % tok_cred_lp == 0) tok_owed[c]++;
        end
        // the link counts a token one cycle after the pulse
        if (io_tok_in[c]) far_cred[c] += tok_cred_lp;
        if (stall_prev[c]) begin
          check("core_fwd_v_o", c, 32'(in_v[c]), 32'd1);
          check("core_fwd_pkt_o", c, 32'(in_pkt[c]), 32'(stall_pkt[c]));
        end
        stall_prev[c] = in_v[c] & ~in_ready[c];
        stall_pkt[c]  = in_pkt[c];
        if (in_v[c] & in_ready[c]) begin
          check("core_fwd_pkt_o", c, 32'(in_pkt[c]), 32'(ref_pkt(c, 64 + deq[c])));
          deq[c]++;
        end
        if (io_tok_out[c]) begin
          in_toks[c]++;
          in_cred[c] += tok_cred_lp;
        end
      end
      cord_ok = 1'b1;
    end
  end

  initial begin
    rst_n = 1'b0;
    pod_tags = '0;
    global_cord = '0;
    out_v = '0;
    out_pkt = '0;
    in_ready = '0;
    io_tok_in = '0;
    io_in = '0;
    for (int c = 0; c < num_cols_lp; c++) begin
      far_cred[c] = fifo_cred_lp;
      in_cred[c] = fifo_cred_lp;
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    for (int c = 0; c < num_cols_lp; c++) begin
      check("core_reset_o", c, 32'(core_reset[c]), 32'd1);
      check("io_fwd_o.v", c, 32'(io_out[c].v), 32'd0);
      check("core_fwd_v_o", c, 32'(in_v[c]), 32'd0);
      check("io_fwd_token_o", c, 32'(io_tok_out[c]), 32'd0);
      check("core_fwd_ready_o", c, 32'(out_ready[c]), 32'd1);
    end
    // release pod 1, its columns drop four edges after the strobe
    @(posedge clk);
    pod_tags[1] <= '{v: 1'b1, data: 1'b0};
    for (int k = 1; k <= 4; k++) begin
      @(posedge clk);
      pod_tags[1] <= '0;
      @(negedge clk);
      for (int c = 0; c < num_cols_lp; c++) begin
        check("core_reset_o", c, 32'(core_reset[c]), 32'((c < 2) || (k < 4)));
      end
    end
    run_links = 1'b1;
    // no tokens yet, so each column stops after the far end buffer depth
    while (min_of(out_rcvd) < fifo_cred_lp) @(posedge clk);
    repeat (6) @(posedge clk);
    for (int c = 0; c < num_cols_lp; c++) begin
      check("io_fwd_o.v count", c, 32'(out_rcvd[c]), 32'(fifo_cred_lp));
    end
    @(negedge clk);
    // far end and local FIFO both full, so enqueue must stall
    for (int c = 0; c < num_cols_lp; c++) begin
      check("core_fwd_ready_o", c, 32'(out_ready[c]), 32'd0);
    end
    tok_en = 1'b1;
    while (min_of(out_rcvd) < num_pkts_lp || min_of(deq) < num_pkts_lp) @(posedge clk);
    repeat (4) @(posedge clk);
    for (int c = 0; c < num_cols_lp; c++) begin
      check("io_fwd_token_o count", c, 32'(in_toks[c]), 32'(deq[c] / tok_cred_lp));
    end
    $display("value errors %0d, protocol errors %0d", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hdl
hdl/sdr_pkg.sv
hdl/sdr_link_out.sv
hdl/sdr_link_in.sv
hdl/sdr_north_tile.sv
hdl/pod_row_sdr_north.sv
tb/pod_row_sdr_chk.sv
tb/tb_pod_row_sdr.sv

/* Makefile */
TOP = tb_pod_row_sdr
LOG = sim.log

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): flist.f hdl/sdr_defines.svh hdl/*.sv tb/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
